// File: mips_cpu.f
+incdir+include
hdl/mips_pkg.sv
hdl/mips_alu.sv
hdl/mips_regfile.sv
hdl/mips_datapath.sv
hdl/mips_control.sv
hdl/mips_cpu.sv
test/mips_mem_model.sv
test/tb_mips_cpu.sv

// File: Bender.yml
package:
  name: mips_cpu

export_include_dirs:
  - include

sources:
  - hdl/mips_pkg.sv
  - hdl/mips_alu.sv
  - hdl/mips_regfile.sv
  - hdl/mips_datapath.sv
  - hdl/mips_control.sv
  - hdl/mips_cpu.sv
  - target: test
    files:
      - test/mips_mem_model.sv
      - test/tb_mips_cpu.sv

// File: test/tb_mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module tb_mips_cpu
    import mips_pkg::*;
();

    localparam int CLK_PERIOD      = 10;
    localparam int RESET_CYCLES    = 16;
    localparam int INSTR_CYCLES    = 10;  // 4 states plus 3 waits on two accesses
    localparam int WATCHDOG_FACTOR = 200;
    localparam int QUIET_CYCLES    = 20;
    localparam int DATA_WORDS      = 64;
    localparam int ALU_TESTS       = 11;

    localparam word_t DATA_BASE   = 32'h00001000;
    localparam word_t ALU_SLOT    = 32'h00001000;
    localparam word_t BRANCH_SLOT = 32'h00001040;
    localparam word_t ZERO_SLOT   = 32'h0000105C;
    localparam word_t LOAD_SLOT   = 32'h00001080;
    localparam word_t TARGET_SLOT = 32'h00001084;

    localparam logic [15:0] IMM_A      = 16'h1234;
    localparam logic [15:0] IMM_B      = 16'h8F0F;
    localparam logic [15:0] IMM_NEG    = 16'hFFFB;
    localparam logic [15:0] IMM_SLTI   = 16'hFFFF;
    localparam logic [15:0] IMM_ORI    = 16'h00AA;
    localparam logic [15:0] ADDEND     = 16'h0321;
    localparam word_t       LOAD_VALUE = 32'h13579BDF;

    logic  clk;
    logic  reset;
    logic  active;
    word_t register_v0;
    word_t address;
    word_t writedata;
    logic  read;
    logic  write;
    logic  waitrequest;
    word_t readdata;

    int    prog_len;
    logic  program_ready;
    int    test_errors;
    int    tests_run;
    int    tests_failed;
    int    protocol_errors;
    word_t alu_expect [ALU_TESTS];
    string alu_names [ALU_TESTS] = '{"ADDIU", "ORI", "ADDIU negative", "ADDU", "SUBU",
                                     "AND", "OR", "XOR", "SLT", "SLT reversed", "SLTI"};

    mips_cpu i_dut (
        .clk         (clk),
        .reset       (reset),
        .active      (active),
        .register_v0 (register_v0),
        .address     (address),
        .writedata   (writedata),
        .read        (read),
        .write       (write),
        .waitrequest (waitrequest),
        .readdata    (readdata)
    );

    mips_mem_model i_mem (
        .clk         (clk),
        .reset       (reset),
        .address     (address),
        .read        (read),
        .write       (write),
        .writedata   (writedata),
        .readdata    (readdata),
        .waitrequest (waitrequest)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    a_one_strobe: assert property (@(posedge clk) disable iff (reset) !(read && write))
        else begin
            $display("Bus protocol: read and write high together at %0t", $time);
            protocol_errors++;
        end

    // Request must hold while the memory stalls
    a_hold_request: assert property (@(posedge clk) disable iff (reset)
        (read || write) && waitrequest |=> $stable(address) && $stable(read)
            && $stable(write) && (!write || $stable(writedata)))
        else begin
            $display("Bus protocol: request changed during waitrequest at %0t", $time);
            protocol_errors++;
        end

    function automatic word_t sign_extend(input logic [15:0] imm);
        return {{16{imm[15]}}, imm};
    endfunction

    function automatic word_t data_marker(input word_t addr);
        return addr ^ 32'hC3A55A3C;
    endfunction

    function automatic word_t instr_addr(input int index);
        return `MIPS_RESET_VECTOR + word_t'(4 * index);
    endfunction

    function automatic logic [15:0] word_offset(input word_t base, input int n);
        word_t addr;
        addr = base + word_t'(4 * n);
        return addr[15:0];
    endfunction

    function automatic word_t rtype_instr(input funct_t funct, input reg_addr_t rs,
                                          input reg_addr_t rt, input reg_addr_t rd);
        return {OP_RTYPE, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic word_t itype_instr(input opcode_t op, input reg_addr_t rs,
                                          input reg_addr_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jtype_instr(input word_t target);
        return {OP_J, target[27:2]};
    endfunction

    task automatic append_instr(input word_t instr);
        i_mem.preload_word(instr_addr(prog_len), instr);
        prog_len++;
    endtask

    task automatic compute_alu_expect();
        word_t a;
        word_t b;
        word_t n;
        a = sign_extend(IMM_A);
        b = {16'h0000, IMM_B};  // ORI is zero extended
        n = sign_extend(IMM_NEG);
        alu_expect[0]  = a;
        alu_expect[1]  = b;
        alu_expect[2]  = n;
        alu_expect[3]  = a + b;
        alu_expect[4]  = a - b;
        alu_expect[5]  = a & b;
        alu_expect[6]  = a | b;
        alu_expect[7]  = a ^ b;
        alu_expect[8]  = ($signed(n) < $signed(a)) ? 32'd1 : 32'd0;
        alu_expect[9]  = ($signed(a) < $signed(n)) ? 32'd1 : 32'd0;
        alu_expect[10] = ($signed(n) < $signed(sign_extend(IMM_SLTI))) ? 32'd1 : 32'd0;
    endtask

    task automatic build_program();
        word_t jr_target;
        for (int i = 0; i < DATA_WORDS; i++) begin
            i_mem.preload_word(DATA_BASE + word_t'(4 * i), data_marker(DATA_BASE + word_t'(4 * i)));
        end
        i_mem.preload_word(LOAD_SLOT, LOAD_VALUE);
        prog_len = 0;
        append_instr(itype_instr(OP_ADDIU, 5'd0, 5'd8, IMM_A));
        append_instr(itype_instr(OP_ORI, 5'd0, 5'd9, IMM_B));
        append_instr(itype_instr(OP_ADDIU, 5'd0, 5'd10, IMM_NEG));
        append_instr(rtype_instr(FN_ADDU, 5'd8, 5'd9, 5'd11));
        append_instr(rtype_instr(FN_SUBU, 5'd8, 5'd9, 5'd12));
        append_instr(rtype_instr(FN_AND, 5'd8, 5'd9, 5'd13));
        append_instr(rtype_instr(FN_OR, 5'd8, 5'd9, 5'd14));
        append_instr(rtype_instr(FN_XOR, 5'd8, 5'd9, 5'd15));
        append_instr(rtype_instr(FN_SLT, 5'd10, 5'd8, 5'd16));
        append_instr(rtype_instr(FN_SLT, 5'd8, 5'd10, 5'd17));
        append_instr(itype_instr(OP_SLTI, 5'd10, 5'd18, IMM_SLTI));
        for (int r = 0; r < ALU_TESTS; r++) begin
            append_instr(itype_instr(OP_SW, 5'd0, reg_addr_t'(8 + r), word_offset(ALU_SLOT, r)));
        end
        append_instr(itype_instr(OP_LW, 5'd0, 5'd19, LOAD_SLOT[15:0]));
        append_instr(itype_instr(OP_ADDIU, 5'd0, 5'd20, ADDEND));
        append_instr(rtype_instr(FN_ADDU, 5'd19, 5'd20, 5'd2));  // Result in v0
        append_instr(itype_instr(OP_BEQ, 5'd8, 5'd8, 16'd1));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd8, word_offset(BRANCH_SLOT, 0)));
        append_instr(itype_instr(OP_BNE, 5'd8, 5'd9, 16'd1));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd8, word_offset(BRANCH_SLOT, 1)));
        append_instr(itype_instr(OP_BNE, 5'd8, 5'd8, 16'd1));  // Falls through
        append_instr(itype_instr(OP_SW, 5'd0, 5'd9, word_offset(BRANCH_SLOT, 2)));
        append_instr(jtype_instr(instr_addr(prog_len + 2)));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd8, word_offset(BRANCH_SLOT, 3)));
        append_instr(itype_instr(OP_ORI, 5'd0, 5'd21, IMM_ORI));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd21, word_offset(BRANCH_SLOT, 4)));
        // No LUI, so the JR target is loaded from data memory
        jr_target = instr_addr(prog_len + 3);
        i_mem.preload_word(TARGET_SLOT, jr_target);
        append_instr(itype_instr(OP_LW, 5'd0, 5'd22, TARGET_SLOT[15:0]));
        append_instr(rtype_instr(FN_JR, 5'd22, 5'd0, 5'd0));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd8, word_offset(BRANCH_SLOT, 5)));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd9, word_offset(BRANCH_SLOT, 6)));
        append_instr(itype_instr(OP_ADDIU, 5'd0, 5'd0, 16'h0055));
        append_instr(itype_instr(OP_SW, 5'd0, 5'd0, ZERO_SLOT[15:0]));
        append_instr(rtype_instr(FN_JR, 5'd0, 5'd0, 5'd0));  // To the halt address
    endtask

    task automatic check_word(input string test, input string what,
                              input word_t expected, input word_t actual);
        assert (actual === expected)
        else begin
            $display("Error %s: %s expected %h, actual %h", test, what, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input string test);
        tests_run++;
        if (test_errors == 0) begin
            $display("Test %s: ok", test);
        end else begin
            $display("Test %s: %0d check(s) failed", test, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    initial begin : watchdog
        int limit_cycles;
        wait (program_ready);
        limit_cycles = WATCHDOG_FACTOR * prog_len * INSTR_CYCLES + RESET_CYCLES;
        #(limit_cycles * CLK_PERIOD);
        $display("Timeout: the CPU did not halt within %0d cycles", limit_cycles);
        $display("Result: FAILED");
        $finish;
    end

    initial begin
        reset           = 1'b1;
        program_ready   = 1'b0;
        test_errors     = 0;
        tests_run       = 0;
        tests_failed    = 0;
        protocol_errors = 0;
        compute_alu_expect();
        build_program();
        program_ready = 1'b1;

        repeat (RESET_CYCLES) @(negedge clk);
        reset <= 1'b0;
        check_word("reset", "active", 32'd1, word_t'(active));
        check_word("reset", "write", 32'd0, word_t'(write));
        check_word("reset", "read", 32'd1, word_t'(read));
        check_word("reset", "fetch address", `MIPS_RESET_VECTOR, address);
        report_test("reset");

        wait (active == 1'b0);
        @(negedge clk);
        for (int i = 0; i < ALU_TESTS; i++) begin
            check_word("alu", alu_names[i], alu_expect[i],
                       i_mem.peek_word(ALU_SLOT + word_t'(4 * i)));
        end
        report_test("alu");

        check_word("load", "v0", LOAD_VALUE + sign_extend(ADDEND), register_v0);
        report_test("load");

        check_word("branch", "BEQ skip", data_marker(BRANCH_SLOT),
                   i_mem.peek_word(BRANCH_SLOT));
        check_word("branch", "BNE skip", data_marker(BRANCH_SLOT + 32'h4),
                   i_mem.peek_word(BRANCH_SLOT + 32'h4));
        check_word("branch", "BNE fall through", {16'h0000, IMM_B},
                   i_mem.peek_word(BRANCH_SLOT + 32'h8));
        check_word("branch", "J skip", data_marker(BRANCH_SLOT + 32'hC),
                   i_mem.peek_word(BRANCH_SLOT + 32'hC));
        check_word("branch", "J target", {16'h0000, IMM_ORI},
                   i_mem.peek_word(BRANCH_SLOT + 32'h10));
        check_word("branch", "JR skip", data_marker(BRANCH_SLOT + 32'h14),
                   i_mem.peek_word(BRANCH_SLOT + 32'h14));
        check_word("branch", "JR target", {16'h0000, IMM_B},
                   i_mem.peek_word(BRANCH_SLOT + 32'h18));
        report_test("branch");

        check_word("zero_reg", "store of r0", 32'd0, i_mem.peek_word(ZERO_SLOT));
        report_test("zero_reg");

        repeat (QUIET_CYCLES) begin
            @(negedge clk);
            assert (!read && !write && !active)
            else begin
                $display("halt: bus strobe or active raised after the jump to address 0");
                test_errors++;
            end
        end
        check_word("halt", "stray writes", 32'd0, word_t'(i_mem.stray_writes));
        report_test("halt");

        $display("Tests run: %0d, failed: %0d, protocol assertion failures: %0d",
                 tests_run, tests_failed, protocol_errors);
        if (tests_failed == 0 && protocol_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/mips_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module mips_mem_model
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  word_t address,
    input  logic  read,
    input  logic  write,
    input  word_t writedata,
    output word_t readdata,
    output logic  waitrequest
);

    localparam int    WORDS     = 64;
    localparam word_t PROG_BASE = `MIPS_RESET_VECTOR;
    localparam word_t DATA_BASE = 32'h00001000;

    word_t       prog_mem [WORDS];
    word_t       data_mem [WORDS];
    logic [31:0] lfsr_state;
    int          stray_writes;
    int          remain;
    logic        in_access;
    logic        granted;  // Waitrequest was low on a live access

    initial begin
        lfsr_state   = 32'h79c00138;
        stray_writes = 0;
        waitrequest  = 1'b1;
        readdata     = '0;
        in_access    = 1'b0;
        granted      = 1'b0;
        remain       = 0;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    // Two LFSR bits give 0 to 3 wait cycles
    task automatic draw_wait(output int cycles);
        cycles = 0;
        for (int i = 0; i < 2; i++) begin
            cycles     = (cycles << 1) | int'(lfsr_state[0]);
            lfsr_state = lfsr_step(lfsr_state);
        end
    endtask

    function automatic word_t peek_word(input word_t addr);
        if (addr[31:8] == PROG_BASE[31:8]) begin
            return prog_mem[addr[7:2]];
        end else if (addr[31:8] == DATA_BASE[31:8]) begin
            return data_mem[addr[7:2]];
        end
        return ~addr;  // Unmapped
    endfunction

    task automatic preload_word(input word_t addr, input word_t data);
        if (addr[31:8] == PROG_BASE[31:8]) begin
            prog_mem[addr[7:2]] = data;
        end else if (addr[31:8] == DATA_BASE[31:8]) begin
            data_mem[addr[7:2]] = data;
        end
    endtask

    always @(negedge clk) begin
        if (reset) begin
            waitrequest <= 1'b1;
            in_access = 1'b0;
            granted   = 1'b0;
        end else begin
            if (granted) begin
                in_access = 1'b0;  // Finished on the last rising edge
                granted   = 1'b0;
            end
            if ((read || write) && !in_access) begin
                in_access = 1'b1;
                draw_wait(remain);
            end
            if (in_access && remain == 0) begin
                waitrequest <= 1'b0;
                granted = 1'b1;
                if (read) begin
                    readdata <= peek_word(address);
                end
            end else begin
                waitrequest <= 1'b1;
                if (in_access) begin
                    remain--;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!reset && write && !waitrequest) begin
            if (address[31:8] == DATA_BASE[31:8]) begin
                data_mem[address[7:2]] <= writedata;
            end else begin
                stray_writes++;
            end
        end
    end

endmodule

`default_nettype wire

// File: hdl/mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu
    import mips_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    output logic  active,
    output word_t register_v0,
    output word_t address,
    output word_t writedata,
    output logic  read,
    output logic  write,
    input  logic  waitrequest,
    input  word_t readdata
);

    dp_ctrl_t      ctrl;
    instr_fields_t instr;
    word_t         pc_out;

    mips_control i_control (
        .clk         (clk),
        .reset       (reset),
        .instr       (instr),
        .pc_out      (pc_out),
        .waitrequest (waitrequest),
        .ctrl        (ctrl),
        .read        (read),
        .write       (write),
        .active      (active)
    );

    mips_datapath i_datapath (
        .clk         (clk),
        .reset       (reset),
        .ctrl        (ctrl),
        .readdata    (readdata),
        .waitrequest (waitrequest),
        .instr       (instr),
        .pc_out      (pc_out),
        .address     (address),
        .writedata   (writedata),
        .register_v0 (register_v0)
    );

endmodule

`default_nettype wire

// File: hdl/mips_control.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module mips_control
    import mips_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  instr_fields_t instr,
    input  word_t         pc_out,
    input  logic          waitrequest,
    output dp_ctrl_t      ctrl,
    output logic          read,
    output logic          write,
    output logic          active
);

    typedef enum logic [2:0] {
        CLS_NOP,
        CLS_ALU_REG,
        CLS_ALU_IMM,
        CLS_LOAD,
        CLS_STORE,
        CLS_BRANCH,
        CLS_JUMP
    } instr_class_t;

    cpu_state_t   state;
    instr_class_t iclass;
    alu_op_t      rtype_op;
    logic         rtype_valid;
    logic         halting;

    assign halting = (pc_out == `MIPS_HALT_ADDR);
    assign active  = (state != HALT);

    always_comb begin
        rtype_valid = 1'b1;
        case (instr.funct)
            FN_ADDU: rtype_op = ALU_ADD;
            FN_SUBU: rtype_op = ALU_SUB;
            FN_AND:  rtype_op = ALU_AND;
            FN_OR:   rtype_op = ALU_OR;
            FN_XOR:  rtype_op = ALU_XOR;
            FN_SLT:  rtype_op = ALU_SLT;
            default: begin
                rtype_op    = ALU_PASS_B;
                rtype_valid = 1'b0;  // JR or unsupported funct
            end
        endcase
    end

    always_comb begin
        case (instr.opcode)
            OP_RTYPE: begin
                if (instr.funct == FN_JR) begin
                    iclass = CLS_JUMP;
                end else begin
                    iclass = rtype_valid ? CLS_ALU_REG : CLS_NOP;
                end
            end
            OP_ADDIU, OP_ORI, OP_SLTI: iclass = CLS_ALU_IMM;
            OP_LW:                     iclass = CLS_LOAD;
            OP_SW:                     iclass = CLS_STORE;
            OP_BEQ, OP_BNE:            iclass = CLS_BRANCH;
            OP_J:                      iclass = CLS_JUMP;
            default:                   iclass = CLS_NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
        end else begin
            case (state)
                FETCH: begin
                    if (halting) begin
                        state <= HALT;
                    end else if (!waitrequest) begin
                        state <= DECODE;
                    end
                end
                DECODE: state <= EXECUTE;
                EXECUTE: begin
                    if (iclass == CLS_LOAD || iclass == CLS_STORE) begin
                        if (!waitrequest) begin
                            state <= (iclass == CLS_LOAD) ? WRITEBACK : FETCH;
                        end
                    end else begin
                        state <= FETCH;
                    end
                end
                WRITEBACK: state <= FETCH;
                default:   state <= HALT;  // Stays until reset
            endcase
        end
    end

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_PASS_B;
        read        = 1'b0;
        write       = 1'b0;
        case (state)
            FETCH: begin
                if (!halting) begin
                    read           = 1'b1;
                    ctrl.ir_write  = 1'b1;
                    ctrl.pc_write  = !waitrequest;  // PC+4 only on accepted fetch
                    ctrl.alu_src_b = SRC_B_FOUR;
                    ctrl.alu_op    = ALU_ADD;
                end
            end
            EXECUTE: begin
                case (iclass)
                    CLS_ALU_REG: begin
                        ctrl.alu_op    = rtype_op;
                        ctrl.reg_write = 1'b1;
                        ctrl.reg_dest  = DEST_RD;
                    end
                    CLS_ALU_IMM: begin
                        ctrl.alu_src_b = SRC_B_IMM;
                        ctrl.reg_write = 1'b1;
                        if (instr.opcode == OP_ORI) begin
                            ctrl.alu_op      = ALU_OR;
                            ctrl.zero_extend = 1'b1;
                        end else if (instr.opcode == OP_SLTI) begin
                            ctrl.alu_op = ALU_SLT;
                        end else begin
                            ctrl.alu_op = ALU_ADD;
                        end
                    end
                    CLS_LOAD, CLS_STORE: begin
                        ctrl.alu_src_b = SRC_B_IMM;
                        ctrl.alu_op    = ALU_ADD;
                        ctrl.addr_sel  = ADDR_ALU;
                        read           = (iclass == CLS_LOAD);
                        write          = (iclass == CLS_STORE);
                    end
                    CLS_BRANCH: begin
                        ctrl.alu_op    = ALU_SUB;  // Zero flag means equal
                        ctrl.branch_eq = (instr.opcode == OP_BEQ);
                        ctrl.branch_ne = (instr.opcode == OP_BNE);
                    end
                    CLS_JUMP: begin
                        ctrl.pc_write = 1'b1;
                        ctrl.pc_src   = (instr.opcode == OP_J) ? PC_JUMP : PC_REG;
                    end
                    default: ;
                endcase
            end
            WRITEBACK: begin
                ctrl.reg_write    = 1'b1;
                ctrl.reg_from_mem = 1'b1;
            end
            default: ;
        endcase
    end

    a_single_strobe: assert property (@(posedge clk) disable iff (reset)
        !(read && write))
        else $error("read and write asserted together");

    // Once halted, the core stays quiet until reset
    a_halt_quiet: assert property (@(posedge clk) disable iff (reset)
        (state == HALT) |=> (state == HALT) && !read && !write
            && !ctrl.reg_write && !ctrl.pc_write && !ctrl.ir_write)
        else $error("activity after halt");

endmodule

`default_nettype wire

// File: hdl/mips_datapath.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module mips_datapath
    import mips_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  dp_ctrl_t      ctrl,
    input  word_t         readdata,
    input  logic          waitrequest,
    output instr_fields_t instr,
    output word_t         pc_out,
    output word_t         address,
    output word_t         writedata,
    output word_t         register_v0
);

    word_t     pc;
    word_t     ir;
    word_t     a_reg;
    word_t     b_reg;
    word_t     mdr;
    word_t     rs_data;
    word_t     rt_data;
    word_t     imm_ext;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    logic      alu_zero;
    logic      branch_taken;
    word_t     branch_target;
    word_t     jump_target;
    word_t     next_pc;
    reg_addr_t wr_addr;
    word_t     wr_data;

    assign instr = '{opcode: ir[31:26], rs: ir[25:21], rt: ir[20:16],
                     rd: ir[15:11], funct: ir[5:0]};

    assign imm_ext = ctrl.zero_extend ? {16'b0, ir[15:0]} : {{16{ir[15]}}, ir[15:0]};

    // Increment path runs PC through the ALU
    assign alu_a = (ctrl.alu_src_b == SRC_B_FOUR) ? pc : a_reg;

    always_comb begin
        case (ctrl.alu_src_b)
            SRC_B_FOUR: alu_b = 32'd4;
            SRC_B_IMM:  alu_b = imm_ext;
            default:    alu_b = b_reg;
        endcase
    end

    mips_alu i_alu (
        .op     (ctrl.alu_op),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .zero   (alu_zero)
    );

    assign branch_taken  = (ctrl.branch_eq && alu_zero) || (ctrl.branch_ne && !alu_zero);
    assign branch_target = pc + {imm_ext[29:0], 2'b00};  // PC already holds PC+4
    assign jump_target   = {pc[31:28], ir[25:0], 2'b00};

    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;
        end else begin
            case (ctrl.pc_src)
                PC_JUMP: next_pc = jump_target;
                PC_REG:  next_pc = a_reg;
                default: next_pc = alu_result;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= `MIPS_RESET_VECTOR;
        end else if (ctrl.pc_write || branch_taken) begin
            pc <= next_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (ctrl.ir_write && !waitrequest) begin
            ir <= readdata;
        end
        if (ctrl.addr_sel == ADDR_ALU && !waitrequest) begin
            mdr <= readdata;  // Only meaningful for LW
        end
        a_reg <= rs_data;
        b_reg <= rt_data;
    end

    assign wr_addr = (ctrl.reg_dest == DEST_RD) ? instr.rd : instr.rt;
    assign wr_data = ctrl.reg_from_mem ? mdr : alu_result;

    mips_regfile i_regfile (
        .clk     (clk),
        .reset   (reset),
        .rs_addr (instr.rs),
        .rt_addr (instr.rt),
        .wr_addr (wr_addr),
        .wr_en   (ctrl.reg_write),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0_data (register_v0)
    );

    assign pc_out    = pc;
    assign address   = (ctrl.addr_sel == ADDR_ALU) ? alu_result : pc;
    assign writedata = b_reg;

endmodule

`default_nettype wire

// File: hdl/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mips_params.svh"

module mips_regfile
    import mips_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  reg_addr_t rs_addr,
    input  reg_addr_t rt_addr,
    input  reg_addr_t wr_addr,
    input  logic      wr_en,
    input  word_t     wr_data,
    output word_t     rs_data,
    output word_t     rt_data,
    output word_t     v0_data
);

    localparam reg_addr_t V0_ADDR = 5'd2;

    word_t regs [`MIPS_NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    assign rs_data = regs[rs_addr];
    assign rt_data = regs[rt_addr];
    assign v0_data = regs[V0_ADDR];

    a_r0_zero: assert property (@(posedge clk) disable iff (reset)
        (rs_addr == '0) |-> (rs_data == '0))
        else $error("register 0 not zero");

endmodule

`default_nettype wire

// File: hdl/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu
    import mips_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result,
    output logic    zero
);

    always_comb begin
        case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            ALU_SLT: begin
                result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;  // Signed compare
            end
            default: begin
                result = b;  // PASS_B
            end
        endcase
    end

    // Branch compare relies on SUB
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;

    localparam opcode_t OP_RTYPE = 6'h00;
    localparam opcode_t OP_J     = 6'h02;
    localparam opcode_t OP_BEQ   = 6'h04;
    localparam opcode_t OP_BNE   = 6'h05;
    localparam opcode_t OP_ADDIU = 6'h09;
    localparam opcode_t OP_SLTI  = 6'h0A;
    localparam opcode_t OP_ORI   = 6'h0D;
    localparam opcode_t OP_LW    = 6'h23;
    localparam opcode_t OP_SW    = 6'h2B;

    localparam funct_t FN_JR   = 6'h08;
    localparam funct_t FN_ADDU = 6'h21;
    localparam funct_t FN_SUBU = 6'h23;
    localparam funct_t FN_AND  = 6'h24;
    localparam funct_t FN_OR   = 6'h25;
    localparam funct_t FN_XOR  = 6'h26;
    localparam funct_t FN_SLT  = 6'h2A;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_op_t;

    typedef enum logic [2:0] {
        FETCH, DECODE, EXECUTE, WRITEBACK, HALT
    } cpu_state_t;

    typedef enum logic [1:0] {PC_INCR, PC_JUMP, PC_REG} pc_src_t;
    typedef enum logic [1:0] {SRC_B_REG, SRC_B_FOUR, SRC_B_IMM} alu_src_b_t;
    typedef enum logic {ADDR_PC, ADDR_ALU} addr_sel_t;
    typedef enum logic {DEST_RT, DEST_RD} reg_dest_t;

    typedef struct packed {
        opcode_t   opcode;
        reg_addr_t rs;
        reg_addr_t rt;
        reg_addr_t rd;
        funct_t    funct;
    } instr_fields_t;

    typedef struct packed {
        logic       ir_write;
        logic       pc_write;
        logic       branch_eq;
        logic       branch_ne;
        pc_src_t    pc_src;
        addr_sel_t  addr_sel;
        alu_src_b_t alu_src_b;
        logic       zero_extend;  // ORI takes the immediate unsigned
        alu_op_t    alu_op;
        logic       reg_write;
        reg_dest_t  reg_dest;
        logic       reg_from_mem;
    } dp_ctrl_t;

endpackage

`default_nettype wire

// File: include/mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// First instruction fetch after reset
`define MIPS_RESET_VECTOR 32'hBFC00000

// Reaching this PC stops the processor
`define MIPS_HALT_ADDR 32'h00000000

`define MIPS_NUM_REGS 32

`endif
